//--- logic/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Data and address width
`define XLEN 32

// Register index width
`define REG_IDX_W 5

// Internal opcode width
`define OP_W 7

// Instruction slots in the dispatcher
`define ISSUE_CREDITS 4

`define RESET_PC 32'h0000_0000

`endif

//--- logic/rv_isa_pkg.sv
`include "fetch_defines.svh"

package rv_isa_pkg;

    // Internal opcode numbering shared with the backend
    typedef enum logic [`OP_W-1:0] {
        OP_NONE = '0,   // Unknown encoding
        OP_LUI,         // 1
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,         // 5
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LB,          // 11
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,          // 16
        OP_SH,
        OP_SW,
        OP_ADDI,        // 19
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_ADD,         // 28
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XORR,
        OP_SRL,
        OP_SRA,
        OP_ORR,
        OP_ANDR         // 37
    } op_e;

    typedef struct packed {
        op_e                    opcode;
        logic [`REG_IDX_W-1:0]  rs1;
        logic [`REG_IDX_W-1:0]  rs2;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`XLEN-1:0]       imm;
    } decoded_t;

endpackage

//--- logic/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;
    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_CACHE,
        WAIT_JALR,
        ISSUE
    } fetch_state_e;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
    } icache_req_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   addr;   // Address the cache actually served
        logic [`XLEN-1:0]   data;
    } icache_rsp_t;

    // Flush and jalr resolution share this shape
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   target;
    } redirect_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        decoded_t           dec;
        logic               predict_taken;
    } issue_t;

endpackage

//--- logic/rv32i_decoder.sv
`include "fetch_defines.svh"

module rv32i_decoder
    import rv_isa_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    output decoded_t         dec
);

    // Major opcodes of RV32I
    localparam logic [6:0] MAJ_LUI    = 7'b0110111;
    localparam logic [6:0] MAJ_AUIPC  = 7'b0010111;
    localparam logic [6:0] MAJ_JAL    = 7'b1101111;
    localparam logic [6:0] MAJ_JALR   = 7'b1100111;
    localparam logic [6:0] MAJ_BRANCH = 7'b1100011;
    localparam logic [6:0] MAJ_LOAD   = 7'b0000011;
    localparam logic [6:0] MAJ_STORE  = 7'b0100011;
    localparam logic [6:0] MAJ_OP_IMM = 7'b0010011;
    localparam logic [6:0] MAJ_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub and sra variants

    logic [6:0]         major;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_b;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_j;
    op_e                op;

    assign major  = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // Opcode selection from major opcode, funct3 and funct7
    always_comb begin
        op = OP_NONE;
        case (major)
            MAJ_LUI:   op = OP_LUI;
            MAJ_AUIPC: op = OP_AUIPC;
            MAJ_JAL:   op = OP_JAL;
            MAJ_JALR:  op = (funct3 == 3'b000) ? OP_JALR : OP_NONE;
            MAJ_BRANCH: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            MAJ_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            MAJ_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            MAJ_OP_IMM: begin
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    3'b001:  op = (funct7 == F7_BASE) ? OP_SLLI : OP_NONE;
                    default: op = (funct7 == F7_BASE) ? OP_SRLI :
                                  (funct7 == F7_ALT)  ? OP_SRAI : OP_NONE;
                endcase
            end
            MAJ_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b001:  op = OP_SLL;
                        3'b010:  op = OP_SLT;
                        3'b011:  op = OP_SLTU;
                        3'b100:  op = OP_XORR;
                        3'b101:  op = OP_SRL;
                        3'b110:  op = OP_ORR;
                        default: op = OP_ANDR;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == 3'b000)
                        op = OP_SUB;
                    else if (funct3 == 3'b101)
                        op = OP_SRA;
                end
            end
            default: op = OP_NONE;
        endcase
    end

    // Operand fields by format, unused ones stay zero
    always_comb begin
        dec = '0;
        if (op != OP_NONE) begin
            dec.opcode = op;
            case (major)
                MAJ_LUI, MAJ_AUIPC: begin
                    dec.rd  = instr[11:7];
                    dec.imm = imm_u;
                end
                MAJ_JAL: begin
                    dec.rd  = instr[11:7];
                    dec.imm = imm_j;
                end
                MAJ_BRANCH: begin
                    dec.rs1 = instr[19:15];
                    dec.rs2 = instr[24:20];
                    dec.imm = imm_b;
                end
                MAJ_STORE: begin
                    dec.rs1 = instr[19:15];
                    dec.rs2 = instr[24:20];
                    dec.imm = imm_s;
                end
                MAJ_OP: begin
                    dec.rs1 = instr[19:15];
                    dec.rs2 = instr[24:20];
                    dec.rd  = instr[11:7];
                end
                default: begin  // jalr, loads and OP-IMM share the I format
                    dec.rs1 = instr[19:15];
                    dec.rd  = instr[11:7];
                    dec.imm = imm_i;
                end
            endcase
        end
    end

endmodule

//--- logic/next_pc_unit.sv
`include "fetch_defines.svh"

module next_pc_unit
    import rv_isa_pkg::*;
(
    input  logic [`XLEN-1:0] pc,
    input  decoded_t         dec,
    input  logic             predict_taken,
    output logic [`XLEN-1:0] next_pc,
    output logic             wait_jalr
);

    logic [`XLEN-1:0] seq_pc;
    logic [`XLEN-1:0] target_pc;

    assign seq_pc    = pc + `XLEN'(4);
    assign target_pc = pc + dec.imm;   // jal and branch offsets are PC relative

    always_comb begin
        case (dec.opcode)
            OP_JAL: begin
                next_pc = target_pc;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                next_pc = predict_taken ? target_pc : seq_pc;
            end
            default: begin
                next_pc = seq_pc;
            end
        endcase
    end

    // Target of jalr is only known once the backend resolves it
    assign wait_jalr = (dec.opcode == OP_JALR);

endmodule

//--- logic/issue_credit_counter.sv
`include "fetch_defines.svh"

module issue_credit_counter (
    input  logic clk_in,
    input  logic rst_in,
    input  logic consume,
    input  logic credit_return,
    output logic has_credit
);

    localparam int CNT_W = $clog2(`ISSUE_CREDITS + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`ISSUE_CREDITS);

    logic [CNT_W-1:0] count;   // Free slots in the dispatcher

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= FULL;
        end else if (consume && !credit_return) begin
            if (count != '0)
                count <= count - CNT_W'(1);
        end else if (credit_return && !consume) begin
            if (count != FULL)
                count <= count + CNT_W'(1);
        end
        // Simultaneous consume and return leaves the count as is
    end

    assign has_credit = (count != '0);

    // Dispatcher never hands back more slots than it was given
    assert property (@(posedge clk_in) disable iff (rst_in)
        credit_return |-> count != FULL);

    // Fetcher only issues into a free slot
    assert property (@(posedge clk_in) disable iff (rst_in)
        consume |-> count != '0);

endmodule

//--- logic/instruction_fetcher.sv
`include "fetch_defines.svh"

module instruction_fetcher
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic                clk_in,
    input  logic                rst_in,
    output icache_req_t         icache_req,
    input  icache_rsp_t         icache_rsp,
    output logic [`XLEN-1:0]    predict_query_pc,
    input  logic                predict_taken,
    input  redirect_t           flush,
    input  redirect_t           jalr_done,
    input  logic                credit_return,
    output issue_t              issue
);

    fetch_state_e       state;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   query_pc;     // PC of the outstanding request
    logic [`XLEN-1:0]   instr_word;
    logic               req_valid;

    logic               issue_valid;
    logic [`XLEN-1:0]   issue_pc;
    decoded_t           issue_dec;
    logic               issue_taken;

    decoded_t           dec;
    logic [`XLEN-1:0]   next_pc;
    logic               wait_jalr;
    logic               has_credit;
    logic               rsp_match;
    logic               issue_fire;

    rv32i_decoder decoder_inst (
        .instr (instr_word),
        .dec   (dec)
    );

    next_pc_unit next_pc_inst (
        .pc            (pc),
        .dec           (dec),
        .predict_taken (predict_taken),
        .next_pc       (next_pc),
        .wait_jalr     (wait_jalr)
    );

    issue_credit_counter credit_inst (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .consume       (issue_valid),   // One slot per issued bundle
        .credit_return (credit_return),
        .has_credit    (has_credit)
    );

    // Stale responses from before a flush carry an old address
    assign rsp_match  = icache_rsp.valid && (icache_rsp.addr == pc);
    assign issue_fire = (state == ISSUE) && has_credit && !flush.valid;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= IDLE;
            pc          <= `XLEN'(`RESET_PC);
            query_pc    <= `XLEN'(`RESET_PC);
            req_valid   <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            req_valid   <= 1'b0;   // Pulses by default
            issue_valid <= 1'b0;
            if (flush.valid) begin
                state <= IDLE;
                pc    <= flush.target;
            end else begin
                case (state)
                    IDLE: begin
                        req_valid <= 1'b1;
                        query_pc  <= pc;
                        state     <= WAIT_CACHE;
                    end
                    WAIT_CACHE: begin
                        if (rsp_match)
                            state <= ISSUE;
                    end
                    WAIT_JALR: begin
                        if (jalr_done.valid) begin
                            pc    <= jalr_done.target;
                            state <= IDLE;
                        end
                    end
                    default: begin   // ISSUE holds until a slot frees up
                        if (issue_fire) begin
                            issue_valid <= 1'b1;
                            pc          <= next_pc;
                            state       <= wait_jalr ? WAIT_JALR : IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == WAIT_CACHE && rsp_match)
            instr_word <= icache_rsp.data;
        if (issue_fire) begin
            issue_pc    <= pc;
            issue_dec   <= dec;
            issue_taken <= predict_taken;
        end
    end

    assign icache_req       = '{valid: req_valid, pc: query_pc};
    assign predict_query_pc = query_pc;
    assign issue            = '{valid: issue_valid, pc: issue_pc, dec: issue_dec,
                                predict_taken: issue_taken};

    // Bundle only reaches the dispatcher while a slot is still counted free
    assert property (@(posedge clk_in) disable iff (rst_in)
        issue.valid |-> has_credit);

    assert property (@(posedge clk_in) disable iff (rst_in)
        icache_req.valid |=> !icache_req.valid);

endmodule

//--- testbench/tb_instruction_fetcher.sv
`include "fetch_defines.svh"

module tb_instruction_fetcher
    import rv_isa_pkg::*;
    import fetch_pkg::*;
();

    localparam int PERIOD           = 100;
    localparam int RESET_CYCLES     = 16;
    localparam int MEM_WORDS        = 256;
    localparam int NUM_TEST_INSTR   = 24;
    localparam int CYCLES_PER_INSTR = 200;
    localparam longint TIMEOUT = longint'(RESET_CYCLES + NUM_TEST_INSTR * CYCLES_PER_INSTR)
                                 * PERIOD;

    typedef struct packed {
        issue_t       iss;
        logic [31:0]  next_pc;
    } expect_t;

    logic         clk_in;
    logic         rst_in;
    icache_req_t  icache_req;
    icache_rsp_t  icache_rsp;
    logic [31:0]  predict_query_pc;
    logic         predict_taken;
    redirect_t    flush;
    redirect_t    jalr_done;
    logic         credit_return;
    issue_t       issue;

    logic [31:0]  mem [MEM_WORDS];
    expect_t      exp_q[$];
    logic [31:0]  req_q[$];        // Requests the cache still owes
    int           seed = 5;
    logic [31:0]  exp_req_pc;
    int           req_count;
    int           issue_count;
    int           paused_issues;
    int           outstanding;     // Issued but not yet credited back
    bit           mem_hold;
    bit           credits_paused;
    bit           in_jalr;

    instruction_fetcher instruction_fetcher_inst (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .icache_req       (icache_req),
        .icache_rsp       (icache_rsp),
        .predict_query_pc (predict_query_pc),
        .predict_taken    (predict_taken),
        .flush            (flush),
        .jalr_done        (jalr_done),
        .credit_return    (credit_return),
        .issue            (issue)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Decode per the RV32I encoding tables and the internal numbering
    function automatic expect_t expected_issue(input logic [31:0] pc, input logic [31:0] word,
                                               input logic taken);
        expect_t     e;
        logic [6:0]  major;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          op;
        major = word[6:0];
        f3    = word[14:12];
        f7    = word[31:25];
        e     = '0;
        op    = 0;
        case (major)
            7'h37: op = 1;
            7'h17: op = 2;
            7'h6f: op = 3;
            7'h67: op = (f3 == 3'd0) ? 4 : 0;
            7'h63: op = (f3 == 3'd2 || f3 == 3'd3) ? 0 : (f3 < 3'd2) ? 5 + int'(f3) : 3 + int'(f3);
            7'h03: op = (f3 < 3'd3) ? 11 + int'(f3) : (f3 == 3'd4 || f3 == 3'd5) ? 10 + int'(f3) : 0;
            7'h23: op = (f3 < 3'd3) ? 16 + int'(f3) : 0;
            7'h13: begin
                if (f3 == 3'd0)
                    op = 19;
                else if (f3 >= 3'd2 && f3 <= 3'd4)
                    op = 18 + int'(f3);
                else if (f3 >= 3'd6)
                    op = 17 + int'(f3);
                else if (f3 == 3'd1)
                    op = (f7 == 7'h00) ? 25 : 0;
                else
                    op = (f7 == 7'h00) ? 26 : (f7 == 7'h20) ? 27 : 0;
            end
            7'h33: begin
                if (f7 == 7'h00)
                    op = (f3 == 3'd0) ? 28 : (f3 < 3'd6) ? 29 + int'(f3) : 30 + int'(f3);
                else if (f7 == 7'h20)
                    op = (f3 == 3'd0) ? 29 : (f3 == 3'd5) ? 35 : 0;
            end
            default: op = 0;
        endcase
        if (op != 0) begin
            e.iss.dec.opcode = op_e'(op[6:0]);
            if (op <= 2) begin            // U format
                e.iss.dec.rd  = word[11:7];
                e.iss.dec.imm = {word[31:12], 12'h000};
            end else if (op == 3) begin   // J format
                e.iss.dec.rd  = word[11:7];
                e.iss.dec.imm = 32'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
            end else if (op >= 5 && op <= 10) begin
                e.iss.dec.rs1 = word[19:15];
                e.iss.dec.rs2 = word[24:20];
                e.iss.dec.imm = 32'($signed({word[31], word[7], word[30:25], word[11:8], 1'b0}));
            end else if (op >= 16 && op <= 18) begin
                e.iss.dec.rs1 = word[19:15];
                e.iss.dec.rs2 = word[24:20];
                e.iss.dec.imm = 32'($signed({word[31:25], word[11:7]}));
            end else if (op >= 28) begin  // R format has no immediate
                e.iss.dec.rs1 = word[19:15];
                e.iss.dec.rs2 = word[24:20];
                e.iss.dec.rd  = word[11:7];
            end else begin
                e.iss.dec.rs1 = word[19:15];
                e.iss.dec.rd  = word[11:7];
                e.iss.dec.imm = 32'($signed(word[31:20]));
            end
        end
        e.iss.valid         = 1'b1;
        e.iss.pc            = pc;
        e.iss.predict_taken = taken;
        if (op == 3 || (op >= 5 && op <= 10 && taken))
            e.next_pc = pc + e.iss.dec.imm;
        else
            e.next_pc = pc + 32'd4;
        return e;
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = {12'(i * 7), 5'(i), 3'b000, 5'(i + 1), 7'h13};  // addi filler
        mem[0]  = 32'h0050_0093;   // addi x1, x0, 5
        mem[1]  = 32'h0080_a103;   // lw x2, 8(x1)
        mem[2]  = 32'hfe20_ae23;   // sw x2, -4(x1)
        mem[3]  = 32'h1234_51b7;   // lui
        mem[4]  = 32'hffff_f217;   // auipc
        mem[5]  = 32'h0020_82b3;   // add
        mem[6]  = 32'h4012_8333;   // sub
        mem[7]  = 32'h0020_8463;   // beq +8, predicted taken at 0x1c
        mem[9]  = 32'h0020_9863;   // bne +16, not taken at 0x24
        mem[10] = 32'h0080_00ef;   // jal +8
        mem[12] = 32'h4030_d393;   // srai
        mem[13] = 32'hffff_ffff;   // Unknown encoding
        mem[14] = 32'h0000_8067;   // jalr x0, 0(x1)
    endtask

    task automatic wait_for_issues(input int target);
        while (issue_count < target)
            @(negedge clk_in);
    endtask

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin : predictor_model
        predict_taken = 1'b0;
        forever begin
            @(negedge clk_in);
            predict_taken = predict_query_pc[3];
        end
    end

    // In-order cache with random latency, answers nothing while held
    initial begin : memory_model
        int          wait_cycles;
        logic [31:0] addr;
        logic [31:0] query_pc;   // PC of the latest request
        icache_rsp  = '0;
        wait_cycles = 0;
        query_pc    = '0;
        forever begin
            @(negedge clk_in);
            icache_rsp = '0;
            if (icache_req.valid) begin
                if (rst_in || in_jalr)
                    abort_run("Cache request seen during reset or while waiting for jalr");
                check_value("icache_req.pc", icache_req.pc, exp_req_pc);
                query_pc = exp_req_pc;
                req_count++;
                req_q.push_back(icache_req.pc);
                if (req_q.size() == 1)
                    wait_cycles = 1 + int'($unsigned($random(seed)) % 4);
            end else if (req_q.size() != 0 && !mem_hold) begin
                if (wait_cycles > 1) begin
                    wait_cycles--;
                end else begin
                    addr = req_q.pop_front();
                    icache_rsp = '{valid: 1'b1, addr: addr, data: mem[addr[9:2]]};
                    if (req_q.size() == 0)   // An older answer behind a newer request is stale
                        exp_q.push_back(expected_issue(addr, mem[addr[9:2]], addr[3]));
                    else
                        wait_cycles = 1 + int'($unsigned($random(seed)) % 4);
                end
            end
            if (req_count > 0)   // Query PC holds until the next request
                check_value("predict_query_pc", predict_query_pc, query_pc);
        end
    end

    initial begin : dispatcher_model
        credit_return = 1'b0;
        outstanding   = 0;
        forever begin
            @(negedge clk_in);
            credit_return = 1'b0;
            if (!credits_paused && outstanding > 0) begin
                credit_return = 1'b1;
                outstanding--;
            end
            if (issue.valid)
                outstanding++;
        end
    end

    initial begin : compare_issues
        expect_t e;
        forever begin
            @(negedge clk_in);
            if (issue.valid) begin
                if (rst_in || exp_q.size() == 0)
                    abort_run("Issue seen without a matching cache response");
                e = exp_q.pop_front();
                check_value("issue.pc", issue.pc, e.iss.pc);
                check_value("issue.dec.opcode", 32'(issue.dec.opcode), 32'(e.iss.dec.opcode));
                check_value("issue.dec.rs1", 32'(issue.dec.rs1), 32'(e.iss.dec.rs1));
                check_value("issue.dec.rs2", 32'(issue.dec.rs2), 32'(e.iss.dec.rs2));
                check_value("issue.dec.rd", 32'(issue.dec.rd), 32'(e.iss.dec.rd));
                check_value("issue.dec.imm", issue.dec.imm, e.iss.dec.imm);
                check_value("issue.predict_taken", 32'(issue.predict_taken),
                            32'(e.iss.predict_taken));
                issue_count++;
                if (credits_paused)
                    paused_issues++;
                if (e.iss.dec.opcode == OP_JALR)
                    in_jalr = 1'b1;
                else
                    exp_req_pc = e.next_pc;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        abort_run("Simulation hung: the fetcher stopped making progress");
    end

    initial begin : test_sequence
        int reqs;
        rst_in         = 1'b1;
        flush          = '0;
        jalr_done      = '0;
        mem_hold       = 1'b0;
        credits_paused = 1'b0;
        in_jalr        = 1'b0;
        exp_req_pc     = `RESET_PC;
        req_count      = 0;
        issue_count    = 0;
        paused_issues  = 0;
        load_program();
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;

        // Straight code, branches and jal up to the jalr
        wait_for_issues(13);
        if (!in_jalr)
            abort_run("The jalr was not the last issued instruction");
        repeat (20) @(negedge clk_in);   // No request may show up here

        credits_paused = 1'b1;
        jalr_done      = '{valid: 1'b1, target: 32'h0000_0100};
        exp_req_pc     = 32'h0000_0100;
        in_jalr        = 1'b0;
        @(negedge clk_in);
        jalr_done = '0;
        repeat (60) @(negedge clk_in);
        if (paused_issues > `ISSUE_CREDITS)
            abort_run("More instructions issued than credits while returns were paused");
        check_value("paused issue count", 32'(paused_issues), 32'(`ISSUE_CREDITS));
        credits_paused = 1'b0;
        wait_for_issues(issue_count + 4);

        // Flush while a response is held back, then release the stale one
        mem_hold = 1'b1;
        repeat (3) @(negedge clk_in);
        reqs       = req_count;
        flush      = '{valid: 1'b1, target: 32'h0000_0200};
        exp_req_pc = 32'h0000_0200;
        @(negedge clk_in);
        flush = '0;
        while (req_count == reqs)
            @(negedge clk_in);
        mem_hold = 1'b0;
        wait_for_issues(issue_count + 3);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- instruction_fetcher.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/rv32i_decoder.sv
logic/next_pc_unit.sv
logic/issue_credit_counter.sv
logic/instruction_fetcher.sv
testbench/tb_instruction_fetcher.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_instruction_fetcher
RTL_TOP   ?= instruction_fetcher
FILELIST  ?= instruction_fetcher.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
